/* include/commit_defs.svh */
`ifndef COMMIT_DEFS_SVH
`define COMMIT_DEFS_SVH

// exception entry, the target of every exception flush
`define COMMIT_EENTRY 32'h1c00_8000

// architectural integer registers, r0 hardwired to zero
`define COMMIT_NREGS 32

// era after reset, the boot vector
`define COMMIT_RESET_ERA 32'h1c00_0000

`endif

/* source/commit_pkg.sv */
`default_nettype none

package commit_pkg;

    // operation class of a retiring instruction
    typedef enum logic [2:0] {
        OP_ALU     = 3'd0,
        OP_LOAD    = 3'd1,
        OP_STORE   = 3'd2,
        OP_SYSCALL = 3'd3,
        OP_BREAK   = 3'd4,
        OP_ERTN    = 3'd5,
        OP_PRIV    = 3'd6
    } op_e;

    // bit index in a lane cause vector, lowest index wins
    typedef enum logic [2:0] {
        CAUSE_INT  = 3'd0,
        CAUSE_ADEF = 3'd1,
        CAUSE_SYS  = 3'd2,
        CAUSE_BRK  = 3'd3,
        CAUSE_INE  = 3'd4,
        CAUSE_ALE  = 3'd5,
        CAUSE_ADEM = 3'd6,
        CAUSE_RSVD = 3'd7
    } cause_e;

    // estat.ecode encodings
    typedef enum logic [5:0] {
        ECODE_INT  = 6'h00,
        ECODE_ADE  = 6'h08,
        ECODE_ALE  = 6'h09,
        ECODE_SYS  = 6'h0b,
        ECODE_BRK  = 6'h0c,
        ECODE_INE  = 6'h0d,
        ECODE_NONE = 6'h3f
    } ecode_e;

endpackage

`default_nettype wire

/* source/retire_latch.sv */
`timescale 1ns/1ps
`default_nettype none

module retire_latch import commit_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_i,
    output logic             ack_o,
    input  wire logic        lane0_valid_i,
    input  wire op_e         lane0_op_i,
    input  wire logic [31:0] lane0_pc_i,
    input  wire logic [4:0]  lane0_rd_i,
    input  wire logic [31:0] lane0_wdata_i,
    input  wire logic [7:0]  lane0_cause_i,
    input  wire logic        lane1_valid_i,
    input  wire op_e         lane1_op_i,
    input  wire logic [31:0] lane1_pc_i,
    input  wire logic [4:0]  lane1_rd_i,
    input  wire logic [31:0] lane1_wdata_i,
    input  wire logic [7:0]  lane1_cause_i,
    output logic             pair_valid_o,
    output logic             lane0_valid_o,
    output op_e              lane0_op_o,
    output logic [31:0]      lane0_pc_o,
    output logic [4:0]       lane0_rd_o,
    output logic [31:0]      lane0_wdata_o,
    output logic [7:0]       lane0_cause_o,
    output logic             lane1_valid_o,
    output op_e              lane1_op_o,
    output logic [31:0]      lane1_pc_o,
    output logic [4:0]       lane1_rd_o,
    output logic [31:0]      lane1_wdata_o,
    output logic [7:0]       lane1_cause_o
);

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        HELD     = 2'd1,
        WAIT_LOW = 2'd2
    } state_e;

    state_e state;

    // held for exactly one cycle after capture
    assign pair_valid_o = (state == HELD);
    assign ack_o        = (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (req_i) state <= HELD;
                HELD:     state <= req_i ? WAIT_LOW : IDLE;
                WAIT_LOW: if (!req_i) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // pair payload, only sampled on the capture edge
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            lane0_valid_o <= lane0_valid_i;
            lane0_op_o    <= lane0_op_i;
            lane0_pc_o    <= lane0_pc_i;
            lane0_rd_o    <= lane0_rd_i;
            lane0_wdata_o <= lane0_wdata_i;
            lane0_cause_o <= lane0_cause_i;
            lane1_valid_o <= lane1_valid_i;
            lane1_op_o    <= lane1_op_i;
            lane1_pc_o    <= lane1_pc_i;
            lane1_rd_o    <= lane1_rd_i;
            lane1_wdata_o <= lane1_wdata_i;
            lane1_cause_o <= lane1_cause_i;
        end
    end

    // ack only ever answers a request seen on the previous edge
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack_o) |-> $past(req_i));

endmodule

`default_nettype wire

/* source/commit_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_defs.svh"

module commit_ctrl import commit_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        pair_valid_i,
    input  wire logic        lane0_valid_i,
    input  wire op_e         lane0_op_i,
    input  wire logic [31:0] lane0_pc_i,
    input  wire logic [4:0]  lane0_rd_i,
    input  wire logic [31:0] lane0_wdata_i,
    input  wire logic [7:0]  lane0_cause_i,
    input  wire logic        lane1_valid_i,
    input  wire op_e         lane1_op_i,
    input  wire logic [31:0] lane1_pc_i,
    input  wire logic [4:0]  lane1_rd_i,
    input  wire logic [31:0] lane1_wdata_i,
    input  wire logic [7:0]  lane1_cause_i,
    input  wire logic        is_pri_instr_i,
    input  wire logic [31:0] era_i,
    output logic             we0_o,
    output logic             we1_o,
    output logic [4:0]       rd0_o,
    output logic [4:0]       rd1_o,
    output logic [31:0]      wd0_o,
    output logic [31:0]      wd1_o,
    output logic             excp_take_o,
    output logic             ertn_take_o,
    output ecode_e           ecode_o,
    output logic [31:0]      era_value_o,
    output logic [31:0]      badv_o,
    output logic             badv_we_o,
    output logic             flush_o,
    output logic             excp_flush_o,
    output logic             ertn_flush_o,
    output logic [31:0]      redirect_pc_o,
    output logic             pri_stall_o
);

    logic   fault0;
    logic   fault1;
    logic   kill1;
    logic   commit0;
    logic   commit1;
    logic   pri_commit;
    logic   [7:0]  sel_cause;
    logic   [31:0] sel_pc;
    logic   [31:0] sel_wdata;
    cause_e top_cause;

    // lowest set bit of a cause vector
    function automatic cause_e first_cause(input logic [7:0] cause);
        cause_e sel;
        sel = CAUSE_RSVD;
        for (int i = 7; i >= 0; i--) begin
            if (cause[i]) sel = cause_e'(i);
        end
        return sel;
    endfunction

    function automatic ecode_e cause_to_ecode(input cause_e c);
        case (c)
            CAUSE_INT:  return ECODE_INT;
            CAUSE_ADEF: return ECODE_ADE;
            CAUSE_SYS:  return ECODE_SYS;
            CAUSE_BRK:  return ECODE_BRK;
            CAUSE_ALE:  return ECODE_ALE;
            CAUSE_ADEM: return ECODE_ADE;
            // reserved slot reports as an invalid instruction
            default:    return ECODE_INE;
        endcase
    endfunction

    assign fault0 = pair_valid_i && lane0_valid_i && (lane0_cause_i != 8'd0);

    // anything behind a fault, syscall, break or ertn is squashed
    assign kill1 = fault0 || (lane0_valid_i &&
                   (lane0_op_i == OP_SYSCALL || lane0_op_i == OP_BREAK ||
                    lane0_op_i == OP_ERTN));

    assign fault1  = pair_valid_i && lane1_valid_i && !kill1 && (lane1_cause_i != 8'd0);
    assign commit0 = pair_valid_i && lane0_valid_i && !fault0;
    assign commit1 = pair_valid_i && lane1_valid_i && !kill1 && !fault1;

    // register writeback, r0 is never a target
    assign we0_o = commit0 && (lane0_rd_i != 5'd0);
    assign we1_o = commit1 && (lane1_rd_i != 5'd0);
    assign rd0_o = lane0_rd_i;
    assign rd1_o = lane1_rd_i;
    assign wd0_o = lane0_wdata_i;
    assign wd1_o = lane1_wdata_i;

    // older lane has priority
    assign sel_cause = fault0 ? lane0_cause_i : lane1_cause_i;
    assign sel_pc    = fault0 ? lane0_pc_i    : lane1_pc_i;
    assign sel_wdata = fault0 ? lane0_wdata_i : lane1_wdata_i;
    assign top_cause = first_cause(sel_cause);

    assign excp_take_o = fault0 || fault1;
    assign ecode_o     = cause_to_ecode(top_cause);
    assign era_value_o = sel_pc;

    always_comb begin
        badv_we_o = 1'b0;
        badv_o    = sel_wdata;
        if (excp_take_o) begin
            case (top_cause)
                CAUSE_ADEF: begin
                    badv_we_o = 1'b1;
                    badv_o    = sel_pc;
                end
                CAUSE_ALE, CAUSE_ADEM: badv_we_o = 1'b1;
                default:               badv_we_o = 1'b0;
            endcase
        end
    end

    assign ertn_take_o = !excp_take_o &&
                         ((commit0 && lane0_op_i == OP_ERTN) ||
                          (commit1 && lane1_op_i == OP_ERTN));

    assign excp_flush_o  = excp_take_o;
    assign ertn_flush_o  = ertn_take_o;
    assign flush_o       = excp_take_o || ertn_take_o;
    assign redirect_pc_o = excp_take_o ? `COMMIT_EENTRY :
                           ertn_take_o ? era_i : 32'd0;

    // privileged ops issue alone, so only lane 0 can retire one
    assign pri_commit = pair_valid_i && lane0_valid_i &&
                        (lane0_op_i == OP_PRIV || lane0_op_i == OP_ERTN);

    always_ff @(posedge clk) begin
        if (rst) begin
            pri_stall_o <= 1'b0;
        end else if (is_pri_instr_i) begin
            pri_stall_o <= 1'b1;
        end else if (pri_commit) begin
            pri_stall_o <= 1'b0;
        end
    end

    excp_ertn_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(excp_take_o && ertn_take_o));

endmodule

`default_nettype wire

/* source/arch_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_defs.svh"

module arch_regfile (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        we0_i,
    input  wire logic        we1_i,
    input  wire logic [4:0]  rd0_i,
    input  wire logic [4:0]  rd1_i,
    input  wire logic [31:0] wd0_i,
    input  wire logic [31:0] wd1_i,
    input  wire logic [4:0]  raddr_i,
    output logic      [31:0] rdata_o
);

    logic [31:0] regs [`COMMIT_NREGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `COMMIT_NREGS; i++) begin
                regs[i] <= 32'd0;
            end
        end else begin
            if (we0_i) regs[rd0_i] <= wd0_i;
            // lane 1 is younger, so its write lands last
            if (we1_i) regs[rd1_i] <= wd1_i;
        end
    end

    assign rdata_o = (raddr_i == 5'd0) ? 32'd0 : regs[raddr_i];

    // commit control must filter r0 writes
    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        !(we0_i && rd0_i == 5'd0) && !(we1_i && rd1_i == 5'd0));

endmodule

`default_nettype wire

/* source/excp_csr.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_defs.svh"

module excp_csr import commit_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        excp_take_i,
    input  wire logic        ertn_take_i,
    input  wire ecode_e      ecode_i,
    input  wire logic [31:0] era_value_i,
    input  wire logic [31:0] badv_i,
    input  wire logic        badv_we_i,
    output logic      [31:0] era_o,
    output ecode_e           ecode_o,
    output logic      [31:0] badv_o,
    output logic             ie_o
);

    logic pie;

    always_ff @(posedge clk) begin
        if (rst) begin
            era_o   <= `COMMIT_RESET_ERA;
            ecode_o <= ECODE_NONE;
            badv_o  <= 32'd0;
            ie_o    <= 1'b1;
            pie     <= 1'b0;
        end else if (excp_take_i) begin
            era_o   <= era_value_i;
            ecode_o <= ecode_i;
            if (badv_we_i) badv_o <= badv_i;
            // stash ie in prmd, mask interrupts in the handler
            pie     <= ie_o;
            ie_o    <= 1'b0;
        end else if (ertn_take_i) begin
            ie_o    <= pie;
        end
    end

endmodule

`default_nettype wire

/* source/commit_top.sv */
`timescale 1ns/1ps
`default_nettype none

module commit_top import commit_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        req_i,
    output logic             ack_o,
    input  wire logic        lane0_valid_i,
    input  wire op_e         lane0_op_i,
    input  wire logic [31:0] lane0_pc_i,
    input  wire logic [4:0]  lane0_rd_i,
    input  wire logic [31:0] lane0_wdata_i,
    input  wire logic [7:0]  lane0_cause_i,
    input  wire logic        lane1_valid_i,
    input  wire op_e         lane1_op_i,
    input  wire logic [31:0] lane1_pc_i,
    input  wire logic [4:0]  lane1_rd_i,
    input  wire logic [31:0] lane1_wdata_i,
    input  wire logic [7:0]  lane1_cause_i,
    input  wire logic        is_pri_instr_i,
    input  wire logic [4:0]  raddr_i,
    output logic      [31:0] rdata_o,
    output logic             flush_o,
    output logic             excp_flush_o,
    output logic             ertn_flush_o,
    output logic      [31:0] redirect_pc_o,
    output logic             pri_stall_o,
    output logic      [31:0] era_o,
    output ecode_e           ecode_o,
    output logic      [31:0] badv_o,
    output logic             ie_o
);

    // latched pair
    logic        pair_valid;
    logic        l0_valid;
    op_e         l0_op;
    logic [31:0] l0_pc;
    logic [4:0]  l0_rd;
    logic [31:0] l0_wdata;
    logic [7:0]  l0_cause;
    logic        l1_valid;
    op_e         l1_op;
    logic [31:0] l1_pc;
    logic [4:0]  l1_rd;
    logic [31:0] l1_wdata;
    logic [7:0]  l1_cause;

    // writeback and csr update
    logic        we0;
    logic        we1;
    logic [4:0]  rd0;
    logic [4:0]  rd1;
    logic [31:0] wd0;
    logic [31:0] wd1;
    logic        excp_take;
    logic        ertn_take;
    ecode_e      ecode;
    logic [31:0] era_value;
    logic [31:0] badv;
    logic        badv_we;

    retire_latch u_retire_latch (
        .clk           (clk),
        .rst           (rst),
        .req_i         (req_i),
        .ack_o         (ack_o),
        .lane0_valid_i (lane0_valid_i),
        .lane0_op_i    (lane0_op_i),
        .lane0_pc_i    (lane0_pc_i),
        .lane0_rd_i    (lane0_rd_i),
        .lane0_wdata_i (lane0_wdata_i),
        .lane0_cause_i (lane0_cause_i),
        .lane1_valid_i (lane1_valid_i),
        .lane1_op_i    (lane1_op_i),
        .lane1_pc_i    (lane1_pc_i),
        .lane1_rd_i    (lane1_rd_i),
        .lane1_wdata_i (lane1_wdata_i),
        .lane1_cause_i (lane1_cause_i),
        .pair_valid_o  (pair_valid),
        .lane0_valid_o (l0_valid),
        .lane0_op_o    (l0_op),
        .lane0_pc_o    (l0_pc),
        .lane0_rd_o    (l0_rd),
        .lane0_wdata_o (l0_wdata),
        .lane0_cause_o (l0_cause),
        .lane1_valid_o (l1_valid),
        .lane1_op_o    (l1_op),
        .lane1_pc_o    (l1_pc),
        .lane1_rd_o    (l1_rd),
        .lane1_wdata_o (l1_wdata),
        .lane1_cause_o (l1_cause)
    );

    commit_ctrl u_commit_ctrl (
        .clk            (clk),
        .rst            (rst),
        .pair_valid_i   (pair_valid),
        .lane0_valid_i  (l0_valid),
        .lane0_op_i     (l0_op),
        .lane0_pc_i     (l0_pc),
        .lane0_rd_i     (l0_rd),
        .lane0_wdata_i  (l0_wdata),
        .lane0_cause_i  (l0_cause),
        .lane1_valid_i  (l1_valid),
        .lane1_op_i     (l1_op),
        .lane1_pc_i     (l1_pc),
        .lane1_rd_i     (l1_rd),
        .lane1_wdata_i  (l1_wdata),
        .lane1_cause_i  (l1_cause),
        .is_pri_instr_i (is_pri_instr_i),
        .era_i          (era_o),
        .we0_o          (we0),
        .we1_o          (we1),
        .rd0_o          (rd0),
        .rd1_o          (rd1),
        .wd0_o          (wd0),
        .wd1_o          (wd1),
        .excp_take_o    (excp_take),
        .ertn_take_o    (ertn_take),
        .ecode_o        (ecode),
        .era_value_o    (era_value),
        .badv_o         (badv),
        .badv_we_o      (badv_we),
        .flush_o        (flush_o),
        .excp_flush_o   (excp_flush_o),
        .ertn_flush_o   (ertn_flush_o),
        .redirect_pc_o  (redirect_pc_o),
        .pri_stall_o    (pri_stall_o)
    );

    arch_regfile u_arch_regfile (
        .clk     (clk),
        .rst     (rst),
        .we0_i   (we0),
        .we1_i   (we1),
        .rd0_i   (rd0),
        .rd1_i   (rd1),
        .wd0_i   (wd0),
        .wd1_i   (wd1),
        .raddr_i (raddr_i),
        .rdata_o (rdata_o)
    );

    excp_csr u_excp_csr (
        .clk         (clk),
        .rst         (rst),
        .excp_take_i (excp_take),
        .ertn_take_i (ertn_take),
        .ecode_i     (ecode),
        .era_value_i (era_value),
        .badv_i      (badv),
        .badv_we_i   (badv_we),
        .era_o       (era_o),
        .ecode_o     (ecode_o),
        .badv_o      (badv_o),
        .ie_o        (ie_o)
    );

endmodule

`default_nettype wire

/* verification/commit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "commit_defs.svh"

module commit_tb import commit_pkg::*;;

    localparam int NUM_PAIRS = 42;
    localparam int TIMEOUT   = 12 * NUM_PAIRS + 100;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_i;
    logic        ack_o;
    logic        lane0_valid_i;
    op_e         lane0_op_i;
    logic [31:0] lane0_pc_i;
    logic [4:0]  lane0_rd_i;
    logic [31:0] lane0_wdata_i;
    logic [7:0]  lane0_cause_i;
    logic        lane1_valid_i;
    op_e         lane1_op_i;
    logic [31:0] lane1_pc_i;
    logic [4:0]  lane1_rd_i;
    logic [31:0] lane1_wdata_i;
    logic [7:0]  lane1_cause_i;
    logic        is_pri_instr_i;
    logic [4:0]  raddr_i;
    logic [31:0] rdata_o;
    logic        flush_o;
    logic        excp_flush_o;
    logic        ertn_flush_o;
    logic [31:0] redirect_pc_o;
    logic        pri_stall_o;
    logic [31:0] era_o;
    ecode_e      ecode_o;
    logic [31:0] badv_o;
    logic        ie_o;

    // next pair to send
    logic        p0_valid;
    op_e         p0_op;
    logic [31:0] p0_pc;
    logic [4:0]  p0_rd;
    logic [31:0] p0_wdata;
    logic [7:0]  p0_cause;
    logic        p1_valid;
    op_e         p1_op;
    logic [31:0] p1_pc;
    logic [4:0]  p1_rd;
    logic [31:0] p1_wdata;
    logic [7:0]  p1_cause;

    // reference model state
    logic [31:0] model_regs [32];
    logic [31:0] model_era;
    ecode_e      model_ecode;
    logic [31:0] model_badv;
    logic        model_ie;
    logic        model_pie;
    logic        model_stall;

    // expectations for the pair in flight
    logic        exp_flush;
    logic        exp_excp_flush;
    logic        exp_ertn_flush;
    logic [31:0] exp_redirect;
    logic [4:0]  exp_rd0;
    logic [4:0]  exp_rd1;
    logic [31:0] exp_val0;
    logic [31:0] exp_val1;

    logic [31:0] lfsr = 32'h8d7b;
    int          errors = 0;
    int          pairs_sent = 0;
    int          commits = 0;
    int          cycles = 0;
    logic        ack_q = 1'b0;
    logic        req_q = 1'b0;

    commit_top dut_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        lsb;
        val = 32'd0;
        for (int i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) lfsr = lfsr ^ 32'h8020_0003;
            val = {val[30:0], lsb};
        end
        return val;
    endfunction

    function automatic op_e pick_op();
        return op_e'(3'(rand_bits(2) % 3));
    endfunction

    function automatic void fill_clean();
        p0_valid = 1'b1;
        p0_op    = pick_op();
        p0_pc    = {30'(rand_bits(30)), 2'b00};
        p0_rd    = 5'(rand_bits(5));
        p0_wdata = rand_bits(32);
        p0_cause = 8'd0;
        p1_valid = 1'b1;
        p1_op    = pick_op();
        p1_pc    = p0_pc + 32'd4;
        p1_rd    = 5'(rand_bits(5));
        p1_wdata = rand_bits(32);
        p1_cause = 8'd0;
    endfunction

    function automatic ecode_e expected_ecode(input logic [2:0] c);
        case (c)
            CAUSE_INT:              return ECODE_INT;
            CAUSE_ADEF, CAUSE_ADEM: return ECODE_ADE;
            CAUSE_SYS:              return ECODE_SYS;
            CAUSE_BRK:              return ECODE_BRK;
            CAUSE_ALE:              return ECODE_ALE;
            default:                return ECODE_INE;
        endcase
    endfunction

    // applies the pending pair to the model and records what the DUT must show
    function automatic void apply_ref();
        logic        f0;
        logic        f1;
        logic        k1;
        logic        c0;
        logic        c1;
        logic [7:0]  cause;
        logic [31:0] pc;
        logic [31:0] wd;
        logic [2:0]  low;
        f0 = p0_valid && (p0_cause != 8'd0);
        k1 = f0 || (p0_valid && (p0_op == OP_SYSCALL || p0_op == OP_BREAK ||
                                 p0_op == OP_ERTN));
        f1 = p1_valid && !k1 && (p1_cause != 8'd0);
        c0 = p0_valid && !f0;
        c1 = p1_valid && !k1 && !f1;
        exp_flush      = 1'b0;
        exp_excp_flush = 1'b0;
        exp_ertn_flush = 1'b0;
        exp_redirect   = 32'd0;
        if (f0 || f1) begin
            cause = f0 ? p0_cause : p1_cause;
            pc    = f0 ? p0_pc : p1_pc;
            wd    = f0 ? p0_wdata : p1_wdata;
            low   = 3'd0;
            while (!cause[low]) low = low + 3'd1;
            exp_flush      = 1'b1;
            exp_excp_flush = 1'b1;
            exp_redirect   = `COMMIT_EENTRY;
            model_era      = pc;
            model_ecode    = expected_ecode(low);
            if (low == CAUSE_ADEF) model_badv = pc;
            else if (low == CAUSE_ALE || low == CAUSE_ADEM) model_badv = wd;
            model_pie = model_ie;
            model_ie  = 1'b0;
        end else if ((c0 && p0_op == OP_ERTN) || (c1 && p1_op == OP_ERTN)) begin
            exp_flush      = 1'b1;
            exp_ertn_flush = 1'b1;
            exp_redirect   = model_era;
            model_ie       = model_pie;
        end
        if (c0 && p0_rd != 5'd0) model_regs[p0_rd] = p0_wdata;
        if (c1 && p1_rd != 5'd0) model_regs[p1_rd] = p1_wdata;
        if (p0_valid && (p0_op == OP_PRIV || p0_op == OP_ERTN)) begin
            model_stall = 1'b0;
        end
        exp_rd0  = p0_rd;
        exp_rd1  = p1_rd;
        exp_val0 = model_regs[p0_rd];
        exp_val1 = model_regs[p1_rd];
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_ecode(input string name, input ecode_e got, input ecode_e exp);
        if (got !== exp) begin
            errors++;
            $display("error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    // one four-phase transfer, then wait for the compare process to finish
    task automatic send_pair();
        apply_ref();
        pairs_sent++;
        @(posedge clk);
        req_i         <= 1'b1;
        lane0_valid_i <= p0_valid;
        lane0_op_i    <= p0_op;
        lane0_pc_i    <= p0_pc;
        lane0_rd_i    <= p0_rd;
        lane0_wdata_i <= p0_wdata;
        lane0_cause_i <= p0_cause;
        lane1_valid_i <= p1_valid;
        lane1_op_i    <= p1_op;
        lane1_pc_i    <= p1_pc;
        lane1_rd_i    <= p1_rd;
        lane1_wdata_i <= p1_wdata;
        lane1_cause_i <= p1_cause;
        do @(posedge clk); while (!ack_o);
        req_i <= 1'b0;
        do @(posedge clk); while (ack_o);
        while (commits < pairs_sent) @(posedge clk);
    endtask

    task automatic pulse_pri();
        @(posedge clk);
        is_pri_instr_i <= 1'b1;
        @(posedge clk);
        is_pri_instr_i <= 1'b0;
        model_stall = 1'b1;
        @(negedge clk);
        check_word("pri_stall_o", 32'(pri_stall_o), 32'(model_stall));
    endtask

    // flush in the ack cycle, then state one and two cycles later
    initial begin : compare_results
        raddr_i = 5'd0;
        forever begin
            @(negedge clk);
            if (!rst && ack_o && !ack_q) begin
                if (!req_q) begin
                    errors++;
                    $display("ack rose although no request was pending");
                end
                check_word("flush_o", 32'(flush_o), 32'(exp_flush));
                check_word("excp_flush_o", 32'(excp_flush_o), 32'(exp_excp_flush));
                check_word("ertn_flush_o", 32'(ertn_flush_o), 32'(exp_ertn_flush));
                check_word("redirect_pc_o", redirect_pc_o, exp_redirect);
                @(posedge clk);
                raddr_i <= exp_rd0;
                @(negedge clk);
                check_word($sformatf("r%0d", exp_rd0), rdata_o, exp_val0);
                check_word("era_o", era_o, model_era);
                check_ecode("ecode_o", ecode_o, model_ecode);
                check_word("badv_o", badv_o, model_badv);
                check_word("ie_o", 32'(ie_o), 32'(model_ie));
                check_word("pri_stall_o", 32'(pri_stall_o), 32'(model_stall));
                @(posedge clk);
                raddr_i <= exp_rd1;
                @(negedge clk);
                check_word($sformatf("r%0d", exp_rd1), rdata_o, exp_val1);
                commits++;
            end
            ack_q = ack_o;
            req_q = req_i;
        end
    end

    initial begin
        rst            = 1'b1;
        req_i          = 1'b0;
        is_pri_instr_i = 1'b0;
        lane0_valid_i  = 1'b0;
        lane0_op_i     = OP_ALU;
        lane0_pc_i     = 32'd0;
        lane0_rd_i     = 5'd0;
        lane0_wdata_i  = 32'd0;
        lane0_cause_i  = 8'd0;
        lane1_valid_i  = 1'b0;
        lane1_op_i     = OP_ALU;
        lane1_pc_i     = 32'd0;
        lane1_rd_i     = 5'd0;
        lane1_wdata_i  = 32'd0;
        lane1_cause_i  = 8'd0;
        for (int i = 0; i < `COMMIT_NREGS; i++) begin
            model_regs[i] = 32'd0;
        end
        model_era   = `COMMIT_RESET_ERA;
        model_ecode = ECODE_NONE;
        model_badv  = 32'd0;
        model_ie    = 1'b1;
        model_pie   = 1'b0;
        model_stall = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("ack_o", 32'(ack_o), 32'd0);
        check_word("flush_o", 32'(flush_o), 32'd0);
        check_word("excp_flush_o", 32'(excp_flush_o), 32'd0);
        check_word("ertn_flush_o", 32'(ertn_flush_o), 32'd0);
        check_word("pri_stall_o", 32'(pri_stall_o), 32'd0);
        check_word("era_o", era_o, model_era);
        check_ecode("ecode_o", ecode_o, model_ecode);
        check_word("ie_o", 32'(ie_o), 32'(model_ie));

        // stall survives the syscall, the ertn after it clears it
        pulse_pri();
        // traps from lane 0, each followed by a return
        fill_clean();
        p0_op    = OP_SYSCALL;
        p0_cause = 8'h04;
        send_pair();
        fill_clean();
        p0_op = OP_ERTN;
        send_pair();
        fill_clean();
        p0_op    = OP_BREAK;
        p0_cause = 8'h08;
        send_pair();
        fill_clean();
        p0_op = OP_ERTN;
        send_pair();
        // break without cause still squashes lane 1
        fill_clean();
        p0_op = OP_BREAK;
        send_pair();
        fill_clean();
        p1_op = OP_ERTN;
        send_pair();

        pulse_pri();
        fill_clean();
        p0_op = OP_PRIV;
        send_pair();
        pulse_pri();
        fill_clean();
        p0_op = OP_ERTN;
        send_pair();

        for (int n = 0; n < 20; n++) begin
            fill_clean();
            if (n % 4 == 3) p1_rd = p0_rd;
            if (n % 5 == 4) p1_valid = 1'b0;
            send_pair();
        end
        // lowest set bit decides, higher bits are noise
        for (int k = 0; k < 8; k++) begin
            fill_clean();
            p0_cause = 8'(rand_bits(8) << k) | 8'(1 << k);
            send_pair();
        end
        for (int k = 1; k < 7; k++) begin
            fill_clean();
            p1_cause = 8'(rand_bits(8) << k) | 8'(1 << k);
            send_pair();
        end

        check_word("commit count", 32'(commits), 32'(pairs_sent));
        $display("errors: %0d, pairs sent: %0d, commits seen: %0d",
                 errors, pairs_sent, commits);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* commit_top.f */
+incdir+include
source/commit_pkg.sv
source/retire_latch.sv
source/commit_ctrl.sv
source/arch_regfile.sv
source/excp_csr.sv
source/commit_top.sv
verification/commit_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := commit_tb
FILELIST := commit_top.f
OBJ_DIR  := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)
